//--- verilog/frontend_pkg.sv
package frontend_pkg;

	// ========================================
	// Thread and width constants
	// ========================================
	localparam int NTHREADS = 4;
	localparam int TID_W = 2;
	localparam int IP_W = 32;
	localparam int INSN_W = 40;

	typedef logic [TID_W-1:0] tid_t;
	typedef logic [IP_W-1:0] code_addr_t;
	typedef logic [INSN_W-1:0] instruction_t;
	typedef logic [NTHREADS-1:0] thread_mask_t;

	// Every instruction is five bytes long
	localparam int INSN_BYTES = 5;

	// Thread t starts at RESET_IP + t * THREAD_IP_STRIDE
	localparam code_addr_t RESET_IP = 32'hFFFC0000;
	localparam code_addr_t THREAD_IP_STRIDE = 32'h100;

	// ========================================
	// Per-thread instruction FIFO
	// ========================================
	localparam int QUEUE_DEPTH = 8;
	// Count must hold the value QUEUE_DEPTH itself
	localparam int QCNT_W = 4;

	// One FIFO entry, pointer in the upper bits
	typedef struct packed {
		code_addr_t ip;
		instruction_t insn;
	} fetch_bundle_t;

endpackage

//--- verilog/fetch_if.sv
`timescale 1ns/10ps

interface fetch_if;
	import frontend_pkg::*;

	// Write strobe with the target thread and the fetched entry
	logic wr;
	tid_t thread;
	fetch_bundle_t bundle;

	// Level, one bit per thread FIFO
	thread_mask_t full;

	modport seq (
		output wr,
		output thread,
		output bundle,
		input  full
	);

	modport queue (
		input  wr,
		input  thread,
		input  bundle,
		output full
	);

endinterface

//--- verilog/issue_queue_if.sv
`timescale 1ns/10ps

interface issue_queue_if;
	import frontend_pkg::*;

	// Oldest entry of every thread FIFO
	fetch_bundle_t head [NTHREADS];

	// Threads that may be read this cycle
	thread_mask_t avail;

	// Pop strobes, at most one bit set
	thread_mask_t rd;

	modport queue (
		output head,
		output avail,
		input  rd
	);

	modport sel (
		input  head,
		input  avail,
		output rd
	);

endinterface

//--- verilog/round_robin_arbiter.sv
`timescale 1ns/10ps

module round_robin_arbiter (
	input  logic clk_g,
	input  logic rst_i,
	input  frontend_pkg::thread_mask_t req_i,
	input  logic advance_i,
	output frontend_pkg::tid_t grant_o,
	output logic grant_valid_o
);
	import frontend_pkg::*;

	// Thread granted last, lowest priority next time
	tid_t last_q;

	// Search starts one past the last grant and wraps around
	always_comb begin
		tid_t cand;
		grant_o = last_q;
		grant_valid_o = 1'b0;
		for (int i = 1; i <= NTHREADS; i++) begin
			cand = last_q + tid_t'(i);
			if (!grant_valid_o && req_i[cand]) begin
				grant_o = cand;
				grant_valid_o = 1'b1;
			end
		end
	end

	// Pointer parks on the last thread so thread 0 wins first
	always_ff @(posedge clk_g) begin
		if (rst_i)
			last_q <= tid_t'(NTHREADS - 1);
		else if (advance_i && grant_valid_o)
			last_q <= grant_o;
	end

	a_grant_requested: assert property (
		@(posedge clk_g) disable iff (rst_i)
		grant_valid_o |-> req_i[grant_o]
	);

endmodule

//--- verilog/fetch_sequencer.sv
`timescale 1ns/10ps

module fetch_sequencer (
	input  logic clk_g,
	input  logic rst_i,
	fetch_if.seq fq,
	input  frontend_pkg::instruction_t insn_i,
	input  logic redirect_i,
	input  frontend_pkg::tid_t redirect_thread_i,
	input  frontend_pkg::code_addr_t redirect_ip_i,
	output logic fetch_valid_o,
	output frontend_pkg::tid_t fetch_thread_o,
	output frontend_pkg::code_addr_t fetch_ip_o
);
	import frontend_pkg::*;

	// One instruction pointer per thread
	code_addr_t ip_q [NTHREADS];

	thread_mask_t redir_mask;
	thread_mask_t req;
	tid_t grant;
	logic grant_v;

	// ========================================
	// Thread choice
	// ========================================

	// A thread being redirected this cycle sits out
	always_comb begin
		redir_mask = '0;
		if (redirect_i)
			redir_mask[redirect_thread_i] = 1'b1;
		req = ~fq.full & ~redir_mask;
	end

	round_robin_arbiter u_fetch_arb (
		.clk_g         (clk_g),
		.rst_i         (rst_i),
		.req_i         (req),
		.advance_i     (grant_v),
		.grant_o       (grant),
		.grant_valid_o (grant_v)
	);

	// Memory answers in the same cycle
	assign fetch_valid_o = grant_v;
	assign fetch_thread_o = grant;
	assign fetch_ip_o = ip_q[grant];

	// Entry goes to the FIFO at the end of this cycle
	assign fq.wr = grant_v;
	assign fq.thread = grant;
	assign fq.bundle = '{ip: ip_q[grant], insn: insn_i};

	// ========================================
	// Pointer update
	// ========================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			for (int t = 0; t < NTHREADS; t++)
				ip_q[t] <= code_addr_t'(RESET_IP + code_addr_t'(t) * THREAD_IP_STRIDE);
		end else begin
			if (grant_v)
				ip_q[grant] <= ip_q[grant] + code_addr_t'(INSN_BYTES);
			// Never the granted thread, see request mask
			if (redirect_i)
				ip_q[redirect_thread_i] <= redirect_ip_i;
		end
	end

	a_no_fetch_into_full: assert property (
		@(posedge clk_g) disable iff (rst_i)
		fq.wr |-> !fq.full[fq.thread]
	);

endmodule

//--- verilog/thread_insn_queue.sv
`timescale 1ns/10ps

module thread_insn_queue (
	input  logic clk_g,
	input  logic rst_i,
	fetch_if.queue fq,
	issue_queue_if.queue iq,
	input  logic redirect_i,
	input  frontend_pkg::tid_t redirect_thread_i
);
	import frontend_pkg::*;

	typedef logic [$clog2(QUEUE_DEPTH)-1:0] qptr_t;

	// Entry storage
	fetch_bundle_t mem_q [NTHREADS][QUEUE_DEPTH];

	// Per-thread control
	qptr_t wptr_q [NTHREADS];
	qptr_t rptr_q [NTHREADS];
	logic [QCNT_W-1:0] cnt_q [NTHREADS];

	thread_mask_t wr_mask;
	thread_mask_t flush_mask;
	thread_mask_t full_w;
	thread_mask_t empty_w;

	// ========================================
	// Status and heads
	// ========================================
	always_comb begin
		for (int t = 0; t < NTHREADS; t++) begin
			wr_mask[t] = fq.wr && (fq.thread == tid_t'(t));
			flush_mask[t] = redirect_i && (redirect_thread_i == tid_t'(t));
			full_w[t] = cnt_q[t] == QCNT_W'(QUEUE_DEPTH);
			empty_w[t] = cnt_q[t] == '0;
			// Hide a FIFO that is flushed at this edge
			iq.avail[t] = !empty_w[t] && !flush_mask[t];
			iq.head[t] = mem_q[t][rptr_q[t]];
		end
	end

	assign fq.full = full_w;

	// ========================================
	// Pointers and counts
	// ========================================
	always_ff @(posedge clk_g) begin
		for (int t = 0; t < NTHREADS; t++) begin
			if (rst_i || flush_mask[t]) begin
				wptr_q[t] <= '0;
				rptr_q[t] <= '0;
				cnt_q[t] <= '0;
			end else begin
				if (wr_mask[t])
					wptr_q[t] <= wptr_q[t] + 1'b1;
				if (iq.rd[t])
					rptr_q[t] <= rptr_q[t] + 1'b1;
				cnt_q[t] <= cnt_q[t] + QCNT_W'(wr_mask[t]) - QCNT_W'(iq.rd[t]);
			end
		end
	end

	// Write lands at the thread's tail
	always_ff @(posedge clk_g) begin
		if (fq.wr)
			mem_q[fq.thread][wptr_q[fq.thread]] <= fq.bundle;
	end

	// Occupancy never passes the depth
	a_no_write_when_full: assert property (
		@(posedge clk_g) disable iff (rst_i)
		fq.wr |-> cnt_q[fq.thread] != QCNT_W'(QUEUE_DEPTH)
	);

	a_no_read_when_empty: assert property (
		@(posedge clk_g) disable iff (rst_i)
		(iq.rd & empty_w) == '0
	);

endmodule

//--- verilog/issue_selector.sv
`timescale 1ns/10ps

module issue_selector (
	input  logic clk_g,
	input  logic rst_i,
	issue_queue_if.sel iq,
	input  logic issue_ready_i,
	output logic issue_valid_o,
	output frontend_pkg::tid_t issue_thread_o,
	output frontend_pkg::code_addr_t issue_ip_o,
	output frontend_pkg::instruction_t issue_insn_o
);
	import frontend_pkg::*;

	tid_t grant;
	logic grant_v;
	logic load;

	// Output register empty or taken this cycle
	assign load = !issue_valid_o || issue_ready_i;

	round_robin_arbiter u_issue_arb (
		.clk_g         (clk_g),
		.rst_i         (rst_i),
		.req_i         (iq.avail),
		.advance_i     (load),
		.grant_o       (grant),
		.grant_valid_o (grant_v)
	);

	// Pop only when the head really moves into the register
	always_comb begin
		iq.rd = '0;
		if (load && grant_v)
			iq.rd[grant] = 1'b1;
	end

	// ========================================
	// Issue register
	// ========================================
	always_ff @(posedge clk_g) begin
		if (rst_i)
			issue_valid_o <= 1'b0;
		else if (load)
			issue_valid_o <= grant_v;
	end

	// Held while stalled
	always_ff @(posedge clk_g) begin
		if (load && grant_v) begin
			issue_thread_o <= grant;
			issue_ip_o <= iq.head[grant].ip;
			issue_insn_o <= iq.head[grant].insn;
		end
	end

	a_single_pop: assert property (
		@(posedge clk_g) disable iff (rst_i)
		$onehot0(iq.rd)
	);

endmodule

//--- verilog/barrel_frontend.sv
`timescale 1ns/10ps

module barrel_frontend (
	input  logic clk_g,
	input  logic rst_i,
	// Instruction memory
	output logic fetch_valid_o,
	output frontend_pkg::tid_t fetch_thread_o,
	output frontend_pkg::code_addr_t fetch_ip_o,
	input  frontend_pkg::instruction_t insn_i,
	// Redirect of one thread
	input  logic redirect_i,
	input  frontend_pkg::tid_t redirect_thread_i,
	input  frontend_pkg::code_addr_t redirect_ip_i,
	// Issue
	input  logic issue_ready_i,
	output logic issue_valid_o,
	output frontend_pkg::tid_t issue_thread_o,
	output frontend_pkg::code_addr_t issue_ip_o,
	output frontend_pkg::instruction_t issue_insn_o
);

	fetch_if fq_if ();
	issue_queue_if iq_if ();

	fetch_sequencer u_seq (
		.clk_g             (clk_g),
		.rst_i             (rst_i),
		.fq                (fq_if.seq),
		.insn_i            (insn_i),
		.redirect_i        (redirect_i),
		.redirect_thread_i (redirect_thread_i),
		.redirect_ip_i     (redirect_ip_i),
		.fetch_valid_o     (fetch_valid_o),
		.fetch_thread_o    (fetch_thread_o),
		.fetch_ip_o        (fetch_ip_o)
	);

	// Redirect also flushes the thread's FIFO
	thread_insn_queue u_queue (
		.clk_g             (clk_g),
		.rst_i             (rst_i),
		.fq                (fq_if.queue),
		.iq                (iq_if.queue),
		.redirect_i        (redirect_i),
		.redirect_thread_i (redirect_thread_i)
	);

	issue_selector u_sel (
		.clk_g          (clk_g),
		.rst_i          (rst_i),
		.iq             (iq_if.sel),
		.issue_ready_i  (issue_ready_i),
		.issue_valid_o  (issue_valid_o),
		.issue_thread_o (issue_thread_o),
		.issue_ip_o     (issue_ip_o),
		.issue_insn_o   (issue_insn_o)
	);

endmodule

//--- dv/tb_barrel_frontend.sv
`timescale 1ns/10ps

module tb_barrel_frontend;
	import frontend_pkg::*;

	// ========================================
	// Run length
	// ========================================
	localparam int RESET_CYC = 3;
	localparam int FIRST_CYC = 20;
	localparam int RANDOM_CYC = 2000;
	localparam int STALL_CYC = 48;
	localparam int TOTAL_CYC = RESET_CYC + FIRST_CYC + RANDOM_CYC + 2 * STALL_CYC + 4;
	localparam int CYCLE_LIMIT = 3 * TOTAL_CYC;

	logic clk_g;
	logic rst_i;
	logic fetch_valid_o;
	tid_t fetch_thread_o;
	code_addr_t fetch_ip_o;
	instruction_t insn_i;
	logic redirect_i;
	tid_t redirect_thread_i;
	code_addr_t redirect_ip_i;
	logic issue_ready_i;
	logic issue_valid_o;
	tid_t issue_thread_o;
	code_addr_t issue_ip_o;
	instruction_t issue_insn_o;

	// Reference model, pointers still expected to issue per thread
	code_addr_t exp_q [NTHREADS][$];
	code_addr_t next_fetch_ip [NTHREADS];
	bit seen_first [NTHREADS];
	bit redirected [NTHREADS];
	bit any_fetch;

	// Issue outputs of the previous cycle for the stall check
	bit stalled_prev;
	tid_t prev_thread;
	code_addr_t prev_ip;
	instruction_t prev_insn;

	int total_errors;
	int test_errors;
	int test_issues;
	int test_count;
	int cycle_cnt = 0;
	int unsigned seed_val;

	barrel_frontend dut (.*);

	// Instruction memory, a scramble of the whole address
	function automatic instruction_t mem_word(code_addr_t ip);
		code_addr_t mix;
		mix = ip ^ {ip[15:0], ip[31:16]} ^ 32'h9e37_79b9;
		return {ip[7:0] ^ ip[31:24], mix};
	endfunction

	function automatic code_addr_t thread_reset_ip(int t);
		return RESET_IP + THREAD_IP_STRIDE * code_addr_t'(t);
	endfunction

	assign insn_i = mem_word(fetch_ip_o);

	initial begin
		clk_g = 1'b0;
		forever #4 clk_g = ~clk_g;
	end

	// ========================================
	// Reporting
	// ========================================
	task automatic value_error(string name, logic [63:0] got, logic [63:0] exp);
		$display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		total_errors++;
		test_errors++;
	endtask

	task automatic plain_error(string msg);
		$display("%s", msg);
		total_errors++;
		test_errors++;
	endtask

	task automatic start_test();
		test_errors = 0;
		test_issues = 0;
	endtask

	task automatic finish_test(string name);
		test_count++;
		$display("Test %s done: %0d issues checked, %0d errors", name, test_issues, test_errors);
	endtask

	// ========================================
	// Monitor, sampled at the falling edge
	// ========================================
	task automatic check_stall();
		if (stalled_prev) begin
			assert (issue_valid_o) else plain_error("issue_valid_o dropped during a stall");
			assert (issue_thread_o == prev_thread)
				else value_error("issue_thread_o", issue_thread_o, prev_thread);
			assert (issue_ip_o == prev_ip) else value_error("issue_ip_o", issue_ip_o, prev_ip);
			assert (issue_insn_o == prev_insn)
				else value_error("issue_insn_o", issue_insn_o, prev_insn);
		end
	endtask

	task automatic check_issue();
		tid_t t;
		code_addr_t exp_ip;
		if (!(issue_valid_o && issue_ready_i))
			return;
		t = issue_thread_o;
		test_issues++;
		if (exp_q[t].size() == 0) begin
			plain_error($sformatf("Issue of thread %0d with nothing outstanding", t));
		end else begin
			exp_ip = exp_q[t].pop_front();
			assert (issue_ip_o == exp_ip) else value_error("issue_ip_o", issue_ip_o, exp_ip);
		end
		assert (issue_insn_o == mem_word(issue_ip_o))
			else value_error("issue_insn_o", issue_insn_o, mem_word(issue_ip_o));
		if (!seen_first[t]) begin
			seen_first[t] = 1'b1;
			if (!redirected[t]) begin
				assert (issue_ip_o == thread_reset_ip(t))
					else value_error("issue_ip_o", issue_ip_o, thread_reset_ip(t));
			end
		end
	endtask

	task automatic apply_redirect();
		tid_t t;
		code_addr_t keep_ip;
		bit keep;
		if (!redirect_i)
			return;
		t = redirect_thread_i;
		assert (!(fetch_valid_o && fetch_thread_o == t))
			else plain_error($sformatf("Thread %0d fetched in its redirect cycle", t));
		// An entry sitting in the issue register survives the flush
		keep = issue_valid_o && !issue_ready_i && issue_thread_o == t && exp_q[t].size() > 0;
		keep_ip = keep ? exp_q[t][0] : '0;
		exp_q[t].delete();
		if (keep)
			exp_q[t].push_back(keep_ip);
		next_fetch_ip[t] = redirect_ip_i;
		redirected[t] = 1'b1;
	endtask

	task automatic check_fetch();
		tid_t t;
		if (!fetch_valid_o)
			return;
		t = fetch_thread_o;
		if (!any_fetch) begin
			any_fetch = 1'b1;
			assert (t == tid_t'(0)) else value_error("fetch_thread_o", t, 0);
		end
		assert (fetch_ip_o == next_fetch_ip[t])
			else value_error("fetch_ip_o", fetch_ip_o, next_fetch_ip[t]);
		exp_q[t].push_back(next_fetch_ip[t]);
		next_fetch_ip[t] = next_fetch_ip[t] + code_addr_t'(INSN_BYTES);
		assert (exp_q[t].size() <= QUEUE_DEPTH + 1)
			else plain_error($sformatf("Thread %0d holds too many outstanding entries", t));
	endtask

	always @(negedge clk_g) begin
		if (!rst_i) begin
			check_stall();
			check_issue();
			apply_redirect();
			check_fetch();
			stalled_prev = issue_valid_o && !issue_ready_i;
			prev_thread = issue_thread_o;
			prev_ip = issue_ip_o;
			prev_insn = issue_insn_o;
		end
	end

	// Ends a run that stops making progress
	always @(posedge clk_g) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic bit all_seen();
		for (int t = 0; t < NTHREADS; t++)
			if (!seen_first[t])
				return 1'b0;
		return 1'b1;
	endfunction

	function automatic int outstanding();
		int n;
		n = 0;
		for (int t = 0; t < NTHREADS; t++)
			n += exp_q[t].size();
		return n;
	endfunction

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		rst_i = 1'b1;
		redirect_i = 1'b0;
		redirect_thread_i = '0;
		redirect_ip_i = '0;
		issue_ready_i = 1'b0;
		for (int t = 0; t < NTHREADS; t++)
			next_fetch_ip[t] = thread_reset_ip(t);
		seed_val = $urandom(32'hde4c);
		repeat (RESET_CYC) @(posedge clk_g);
		#1;
		assert (!issue_valid_o) else value_error("issue_valid_o", issue_valid_o, 0);
		rst_i = 1'b0;

		// First issue of every thread, no redirects yet
		start_test();
		issue_ready_i = 1'b1;
		while (!all_seen()) begin
			@(posedge clk_g);
			#1;
		end
		finish_test("reset_and_first_issue");

		// Random back-pressure and rare redirects
		start_test();
		repeat (RANDOM_CYC) begin
			@(posedge clk_g);
			#1;
			issue_ready_i = ($urandom % 100) < 70;
			redirect_i = ($urandom % 100) < 3;
			redirect_thread_i = tid_t'($urandom % NTHREADS);
			redirect_ip_i = $urandom & 32'hFFFF_FFF0;
		end
		@(posedge clk_g);
		#1;
		redirect_i = 1'b0;
		finish_test("random_traffic");

		// Long stall fills every FIFO, then the backlog drains
		start_test();
		issue_ready_i = 1'b0;
		repeat (STALL_CYC) begin
			@(posedge clk_g);
			#1;
		end
		assert (!fetch_valid_o) else plain_error("Fetch continued with every FIFO full");
		assert (outstanding() == NTHREADS * QUEUE_DEPTH + 1)
			else value_error("outstanding entries", outstanding(), NTHREADS * QUEUE_DEPTH + 1);
		issue_ready_i = 1'b1;
		repeat (STALL_CYC) begin
			@(posedge clk_g);
			#1;
		end
		@(negedge clk_g);
		#1;
		// Full FIFOs and a ready consumer give one issue every cycle
		assert (test_issues >= STALL_CYC)
			else plain_error("Backlog did not drain after the full stall");
		finish_test("full_stall_and_drain");

		$display("Tests run: %0d, errors: %0d", test_count, total_errors);
		if (total_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- compile.f
verilog/frontend_pkg.sv
verilog/fetch_if.sv
verilog/issue_queue_if.sv
verilog/round_robin_arbiter.sv
verilog/fetch_sequencer.sv
verilog/thread_insn_queue.sv
verilog/issue_selector.sv
verilog/barrel_frontend.sv
dv/tb_barrel_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the barrel front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_barrel_frontend

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_barrel_frontend
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
	exit 0
fi
exit 1
